// ==== hdl/systolic_settings.svh ====
`ifndef SYSTOLIC_SETTINGS_SVH
`define SYSTOLIC_SETTINGS_SVH

// ------------------------------
// datapath and memory sizing
// ------------------------------

`define SYS_DATA_W 8     // arithmetic wraps at this width.
`define SYS_ADDR_W 6     // 64-word external memory.

// ------------------------------
// array geometry
// ------------------------------

`define SYS_N 3          // array is SYS_N x SYS_N processing elements.

`endif

// ==== hdl/systolic_pkg.sv ====
`include "systolic_settings.svh"

package systolic_pkg;

    // ------------------------------
    // operand transport
    // ------------------------------

    // one stream cycle at the left edge of the array.
    typedef struct packed {
        logic                               valid;
        logic [`SYS_N-1:0][`SYS_DATA_W-1:0] a;      // a[k] enters array row k.
    } feature_row_t;

    // one weight on its way to the PE picked by the one-hot enable.
    typedef struct packed {
        logic [`SYS_DATA_W-1:0]      value;
        logic [`SYS_N*`SYS_N-1:0]    en;            // bit 3k+j selects PE(k,j).
    } weight_load_t;

    // ------------------------------
    // results
    // ------------------------------

    // partial sums leaving the bottom row, one per column.
    typedef struct packed {
        logic [`SYS_N-1:0][`SYS_DATA_W-1:0] col;
    } col_sums_t;

    // 2x2 window of the product matrix.
    typedef struct packed {
        logic [`SYS_DATA_W-1:0] c11;
        logic [`SYS_DATA_W-1:0] c12;
        logic [`SYS_DATA_W-1:0] c21;
        logic [`SYS_DATA_W-1:0] c22;
    } quad_t;

endpackage

// ==== hdl/weight_preloader.sv ====
`timescale 1ns/1ns
`include "systolic_settings.svh"

module weight_preloader (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       start,
    input  logic [`SYS_DATA_W-1:0]     rdata,
    output logic [`SYS_ADDR_W-1:0]     addr,
    output systolic_pkg::weight_load_t wload,
    output logic                       done
);
    localparam int NN     = `SYS_N * `SYS_N;
    localparam int STEP_W = $clog2(NN + 2);

    logic              busy;
    logic [STEP_W-1:0] step;    // cycles since start.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            step <= '0;
            addr <= '0;
            done <= 1'b0;
        end else if (start && !busy) begin
            busy <= 1'b1;
            step <= '0;
            addr <= '0;
            done <= 1'b0;
        end else if (busy) begin
            step <= step + 1'b1;
            if (step < STEP_W'(NN - 1)) begin
                addr <= addr + 1'b1;    // issue phase.
            end
            if (step == STEP_W'(NN + 1)) begin
                busy <= 1'b0;           // last weight went in one cycle ago.
                done <= 1'b1;
            end
        end
    end

    // word for address s-1 is on rdata while step is s.
    always_comb begin
        wload.value = rdata;
        wload.en    = '0;
        if (busy && step != '0 && step <= STEP_W'(NN)) begin
            wload.en[step - 1'b1] = 1'b1;
        end
    end

endmodule

// ==== hdl/feature_loader.sv ====
`timescale 1ns/1ns
`include "systolic_settings.svh"

module feature_loader (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       start,
    input  logic [`SYS_ADDR_W-1:0]     base,
    input  logic [`SYS_DATA_W-1:0]     rdata,
    output logic [`SYS_ADDR_W-1:0]     addr,
    output systolic_pkg::feature_row_t frow,
    output logic                       done
);
    localparam int NN        = `SYS_N * `SYS_N;
    localparam int STREAM_LO = NN + 1;                  // first stream step.
    localparam int STREAM_HI = STREAM_LO + 2 * `SYS_N - 2;
    localparam int STEP_W    = $clog2(STREAM_HI + 1);

    logic                   busy;
    logic [STEP_W-1:0]      step;
    logic [`SYS_DATA_W-1:0] fbuf [NN];      // A[r][k] kept at r*N+k.

    // ------------------------------
    // fetch sequencing
    // ------------------------------

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            step <= '0;
            addr <= '0;
            done <= 1'b0;
        end else if (start && !busy) begin
            busy <= 1'b1;
            step <= '0;
            addr <= base;
            done <= 1'b0;
        end else if (busy) begin
            step <= step + 1'b1;
            if (step < STEP_W'(NN - 1)) begin
                addr <= addr + 1'b1;
            end
            if (step == STEP_W'(STREAM_HI)) begin
                busy <= 1'b0;
                done <= 1'b1;       // stream has ended.
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NN; i++) begin
                fbuf[i] <= '0;
            end
        end else if (busy && step != '0 && step <= STEP_W'(NN)) begin
            fbuf[step - 1'b1] <= rdata;
        end
    end

    // ------------------------------
    // skewed stream
    // ------------------------------

    always_comb begin
        int t;
        int r;
        t    = 0;
        r    = 0;
        frow = '0;
        if (busy && step >= STEP_W'(STREAM_LO)) begin
            t          = int'(step) - STREAM_LO;
            frow.valid = 1'b1;
            for (int k = 0; k < `SYS_N; k++) begin
                r = t - k;                      // row k lags by k cycles.
                if (r >= 0 && r < `SYS_N) begin
                    frow.a[k] = fbuf[r * `SYS_N + k];
                end
            end
        end
    end

endmodule

// ==== hdl/operand_fetch.sv ====
`timescale 1ns/1ns
`include "systolic_settings.svh"

module operand_fetch (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       weight_start,
    input  logic                       feature_start,
    input  logic [`SYS_ADDR_W-1:0]     feature_base,
    input  logic                       mode,
    input  logic [`SYS_DATA_W-1:0]     mem_rdata,
    output logic [`SYS_ADDR_W-1:0]     mem_addr,
    output systolic_pkg::weight_load_t wload,
    output systolic_pkg::feature_row_t frow,
    output logic                       weight_done,
    output logic                       feature_done
);
    logic                   mode_d;     // owner of the word now on mem_rdata.
    logic [`SYS_ADDR_W-1:0] w_addr;
    logic [`SYS_ADDR_W-1:0] f_addr;
    logic [`SYS_DATA_W-1:0] w_rdata;
    logic [`SYS_DATA_W-1:0] f_rdata;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mode_d <= 1'b0;
        end else begin
            mode_d <= mode;
        end
    end

    assign mem_addr = mode ? f_addr : w_addr;
    assign w_rdata  = mode_d ? '0 : mem_rdata;
    assign f_rdata  = mode_d ? mem_rdata : '0;

    weight_preloader weight_preloader_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (weight_start),
        .rdata  (w_rdata),
        .addr   (w_addr),
        .wload  (wload),
        .done   (weight_done)
    );

    feature_loader feature_loader_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (feature_start),
        .base   (feature_base),
        .rdata  (f_rdata),
        .addr   (f_addr),
        .frow   (frow),
        .done   (feature_done)
    );

endmodule

// ==== hdl/pe.sv ====
`timescale 1ns/1ns
`include "systolic_settings.svh"

module pe (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   w_en,
    input  logic [`SYS_DATA_W-1:0] w_in,
    input  logic [`SYS_DATA_W-1:0] a_in,
    input  logic [`SYS_DATA_W-1:0] s_in,
    output logic [`SYS_DATA_W-1:0] a_out,
    output logic [`SYS_DATA_W-1:0] s_out
);
    logic [`SYS_DATA_W-1:0] w_q;    // stationary weight.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            w_q   <= '0;
            a_out <= '0;
            s_out <= '0;
        end else begin
            if (w_en) begin
                w_q <= w_in;
            end
            a_out <= a_in;                  // on to the right neighbour.
            s_out <= s_in + a_in * w_q;     // wraps at data width.
        end
    end

endmodule

// ==== hdl/systolic_array.sv ====
`timescale 1ns/1ns
`include "systolic_settings.svh"

module systolic_array (
    input  logic                       clk,
    input  logic                       arst_n,
    input  systolic_pkg::weight_load_t wload,
    input  systolic_pkg::feature_row_t frow,
    output systolic_pkg::col_sums_t    sums
);
    // a_link[k][j] is the feature entering PE(k,j) and s_link[k][j] the sum leaving it.
    logic [`SYS_DATA_W-1:0] a_link [`SYS_N][`SYS_N];
    logic [`SYS_DATA_W-1:0] s_link [`SYS_N][`SYS_N];

    for (genvar k = 0; k < `SYS_N; k++) begin : g_row
        assign a_link[k][0] = frow.a[k];

        for (genvar j = 0; j < `SYS_N; j++) begin : g_col
            logic [`SYS_DATA_W-1:0] s_top;

            if (k == 0) begin : g_top
                assign s_top = '0;
            end else begin : g_inner
                assign s_top = s_link[k-1][j];
            end

            if (j < `SYS_N - 1) begin : g_pass
                pe pe_inst (
                    .clk    (clk),
                    .arst_n (arst_n),
                    .w_en   (wload.en[k*`SYS_N + j]),
                    .w_in   (wload.value),
                    .a_in   (a_link[k][j]),
                    .s_in   (s_top),
                    .a_out  (a_link[k][j+1]),
                    .s_out  (s_link[k][j])
                );
            end else begin : g_edge
                pe pe_inst (
                    .clk    (clk),
                    .arst_n (arst_n),
                    .w_en   (wload.en[k*`SYS_N + j]),
                    .w_in   (wload.value),
                    .a_in   (a_link[k][j]),
                    .s_in   (s_top),
                    .a_out  (),                 // feature leaves the array here.
                    .s_out  (s_link[k][j])
                );
            end
        end
    end

    for (genvar j = 0; j < `SYS_N; j++) begin : g_bottom
        assign sums.col[j] = s_link[`SYS_N-1][j];
    end

endmodule

// ==== hdl/result_collector.sv ====
`timescale 1ns/1ns
`include "systolic_settings.svh"

module result_collector (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    frow_valid,
    input  systolic_pkg::col_sums_t sums,
    input  logic [1:0]              quad_sel,
    output systolic_pkg::quad_t     quad,
    output logic                    result_ready
);
    localparam int LAST  = 3 * `SYS_N - 2;     // C[N-1][N-1] arrives here.
    localparam int CNT_W = $clog2(LAST + 1);

    logic                   running;
    logic [CNT_W-1:0]       cnt;    // cycles since stream cycle 0.
    logic [`SYS_DATA_W-1:0] c_mat [`SYS_N][`SYS_N];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            running      <= 1'b0;
            cnt          <= '0;
            result_ready <= 1'b0;
            for (int r = 0; r < `SYS_N; r++) begin
                for (int j = 0; j < `SYS_N; j++) begin
                    c_mat[r][j] <= '0;
                end
            end
        end else if (frow_valid && !running) begin
            running      <= 1'b1;
            cnt          <= CNT_W'(1);
            result_ready <= 1'b0;
            for (int r = 0; r < `SYS_N; r++) begin
                for (int j = 0; j < `SYS_N; j++) begin
                    c_mat[r][j] <= '0;      // drop the previous product.
                end
            end
        end else if (running) begin
            cnt <= cnt + 1'b1;
            // column j is j cycles behind column 0 at the bottom edge.
            for (int j = 0; j < `SYS_N; j++) begin
                for (int r = 0; r < `SYS_N; r++) begin
                    if (cnt == CNT_W'(`SYS_N + j + r)) begin
                        c_mat[r][j] <= sums.col[j];
                    end
                end
            end
            if (cnt == CNT_W'(LAST)) begin
                running      <= 1'b0;
                result_ready <= 1'b1;
            end
        end
    end

    // ------------------------------
    // quadrant select
    // ------------------------------

    always_comb begin
        int ro;
        int co;
        ro       = int'(quad_sel[1]);
        co       = int'(quad_sel[0]);
        quad.c11 = c_mat[ro][co];
        quad.c12 = c_mat[ro][co+1];
        quad.c21 = c_mat[ro+1][co];
        quad.c22 = c_mat[ro+1][co+1];
    end

endmodule

// ==== hdl/systolic_top.sv ====
`timescale 1ns/1ns
`include "systolic_settings.svh"

module systolic_top (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   weight_start,
    input  logic                   feature_start,
    input  logic [`SYS_ADDR_W-1:0] feature_base,
    input  logic                   mode,
    input  logic [1:0]             quad_sel,
    input  logic [`SYS_DATA_W-1:0] mem_rdata,
    output logic [`SYS_ADDR_W-1:0] mem_addr,
    output logic                   weight_done,
    output logic                   feature_done,
    output logic                   result_ready,
    output systolic_pkg::quad_t    quad
);
    import systolic_pkg::*;

    weight_load_t wload;
    feature_row_t frow;
    col_sums_t    sums;

    // decode.
    operand_fetch operand_fetch_inst (
        .clk           (clk),
        .arst_n        (arst_n),
        .weight_start  (weight_start),
        .feature_start (feature_start),
        .feature_base  (feature_base),
        .mode          (mode),
        .mem_rdata     (mem_rdata),
        .mem_addr      (mem_addr),
        .wload         (wload),
        .frow          (frow),
        .weight_done   (weight_done),
        .feature_done  (feature_done)
    );

    // execute.
    systolic_array systolic_array_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .wload  (wload),
        .frow   (frow),
        .sums   (sums)
    );

    // result.
    result_collector result_collector_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .frow_valid   (frow.valid),
        .sums         (sums),
        .quad_sel     (quad_sel),
        .quad         (quad),
        .result_ready (result_ready)
    );

endmodule

// ==== testbench/systolic_props.sv ====
`timescale 1ns/1ns

module systolic_props (
    input logic clk,
    input logic arst_n,
    input logic mode,
    input logic weight_done,
    input logic feature_done,
    input logic result_ready
);
    int reset_fails = 0;
    int owner_fails = 0;
    int hold_fails  = 0;

    reset_low: assert property (@(posedge clk) !arst_n |-> !weight_done && !result_ready)
        else begin
            $error("weight_done or result_ready high during reset");
            reset_fails++;
        end

    // a done flag rises only while its own loader owns the port.
    owner_match: assert property (@(posedge clk) disable iff (!arst_n)
        !($rose(weight_done) && mode) && !($rose(result_ready) && !mode))
        else begin
            $error("done flag rose while the other loader owned the port");
            owner_fails++;
        end

    // feature_done is only cleared by an accepted feature_start.
    ready_hold: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(result_ready) |-> !feature_done)
        else begin
            $error("result_ready dropped without a new feature load");
            hold_fails++;
        end

endmodule

bind systolic_top systolic_props systolic_props_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .mode         (mode),
    .weight_done  (weight_done),
    .feature_done (feature_done),
    .result_ready (result_ready)
);

// ==== testbench/systolic_tb.sv ====
`timescale 1ns/1ns
`include "systolic_settings.svh"

module systolic_tb;
    import systolic_pkg::*;

    localparam int NN           = `SYS_N * `SYS_N;
    localparam int ROUNDS       = 12;
    localparam int ROUND_CYCLES = 40;       // one weight load, one feature load, four reads.
    localparam int LOAD_LIMIT   = 40;
    localparam int WATCHDOG_NS  = (ROUNDS * ROUND_CYCLES * 2 + 50) * 10;

    logic                   clk;
    logic                   arst_n;
    logic                   weight_start;
    logic                   feature_start;
    logic [`SYS_ADDR_W-1:0] feature_base;
    logic                   mode;
    logic [1:0]             quad_sel;
    logic [`SYS_DATA_W-1:0] mem_rdata = '0;
    logic [`SYS_ADDR_W-1:0] mem_addr;
    logic                   weight_done;
    logic                   feature_done;
    logic                   result_ready;
    quad_t                  quad;

    logic [`SYS_DATA_W-1:0] mem [2**`SYS_ADDR_W];
    logic [`SYS_ADDR_W-1:0] rd_addr;
    int                     b_held [NN];    // B[k][j] as the PEs hold it, at 3k+j.
    int                     errors;

    systolic_top systolic_top_inst (
        .clk           (clk),
        .arst_n        (arst_n),
        .weight_start  (weight_start),
        .feature_start (feature_start),
        .feature_base  (feature_base),
        .mode          (mode),
        .quad_sel      (quad_sel),
        .mem_rdata     (mem_rdata),
        .mem_addr      (mem_addr),
        .weight_done   (weight_done),
        .feature_done  (feature_done),
        .result_ready  (result_ready),
        .quad          (quad)
    );

    always #5 clk = ~clk;

    // read latency of one cycle.
    always @(posedge clk) begin
        rd_addr = mem_addr;
        #1;
        mem_rdata = mem[rd_addr];
    end

    // ------------------------------
    // helpers
    // ------------------------------

    task automatic report_mismatch(input string test, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("ERROR %s: expected %0h, actual %0h", test, expected, actual);
    endtask

    task automatic fill_memory();
        for (int a = 0; a < 2**`SYS_ADDR_W; a++) begin
            mem[a] = `SYS_DATA_W'($urandom);
        end
    endtask

    // restart_at is the cycle of an extra start pulse or -1 for none.
    task automatic load_weights(input int restart_at);
        int n;
        @(posedge clk);
        #1;
        mode         = 1'b0;
        weight_start = 1'b1;
        @(posedge clk);
        #1;
        weight_start = 1'b0;
        @(negedge clk);
        n = 0;
        while (!weight_done && n < LOAD_LIMIT) begin
            if (n < NN && mem_addr != `SYS_ADDR_W'(n)) begin
                report_mismatch("weight address", 32'(n), 32'(mem_addr));
            end
            @(posedge clk);
            #1;
            weight_start = (n + 1 == restart_at);
            @(negedge clk);
            n++;
        end
        // nine reads, one capture lag, one cycle to flag done.
        if (!weight_done) begin
            errors++;
            $display("weight_done did not rise within %0d cycles of weight_start", LOAD_LIMIT);
        end else if (n != 11) begin
            report_mismatch("weight done latency", 32'd11, 32'(n));
        end
        for (int i = 0; i < NN; i++) begin
            b_held[i] = int'(mem[i]);
        end
    endtask

    task automatic load_features(input logic [`SYS_ADDR_W-1:0] base, input int restart_at);
        int n;
        int fdone_at;
        @(posedge clk);
        #1;
        mode          = 1'b1;
        feature_base  = base;
        feature_start = 1'b1;
        @(posedge clk);
        #1;
        feature_start = 1'b0;
        feature_base  = ~base;      // only sampled on an accepted start.
        @(negedge clk);
        n        = 0;
        fdone_at = -1;
        while (!(result_ready && feature_done) && n < LOAD_LIMIT) begin
            if (n < NN && mem_addr != base + `SYS_ADDR_W'(n)) begin
                report_mismatch("feature address", 32'(base) + 32'(n), 32'(mem_addr));
            end
            if (feature_done && fdone_at < 0) begin
                fdone_at = n;
            end
            @(posedge clk);
            #1;
            feature_start = (n + 1 == restart_at);
            @(negedge clk);
            n++;
        end
        // ten fill cycles, then the deskew of 3+2+2+1 cycles.
        if (!result_ready) begin
            errors++;
            $display("result_ready did not rise within %0d cycles of feature_start", LOAD_LIMIT);
        end else if (n != 18) begin
            report_mismatch("result ready latency", 32'd18, 32'(n));
        end
        // ten fill cycles, then five stream cycles.
        if (fdone_at < 0) begin
            errors++;
            $display("feature_done did not rise within %0d cycles of feature_start", LOAD_LIMIT);
        end else if (fdone_at != 15) begin
            report_mismatch("feature done latency", 32'd15, 32'(fdone_at));
        end
    endtask

    task automatic check_product(input logic [`SYS_ADDR_W-1:0] base);
        int    c [`SYS_N][`SYS_N];
        int    ro;
        int    co;
        quad_t expected;
        for (int r = 0; r < `SYS_N; r++) begin
            for (int j = 0; j < `SYS_N; j++) begin
                c[r][j] = 0;
                for (int k = 0; k < `SYS_N; k++) begin
                    c[r][j] = c[r][j] + int'(mem[int'(base) + 3 * r + k]) * b_held[3 * k + j];
                end
                c[r][j] = c[r][j] % 256;
            end
        end
        for (int q = 0; q < 4; q++) begin
            @(posedge clk);
            #1;
            quad_sel = 2'(q);
            @(negedge clk);
            ro           = q / 2;       // 0 and 1 are the top rows.
            co           = q % 2;
            expected.c11 = `SYS_DATA_W'(c[ro][co]);
            expected.c12 = `SYS_DATA_W'(c[ro][co+1]);
            expected.c21 = `SYS_DATA_W'(c[ro+1][co]);
            expected.c22 = `SYS_DATA_W'(c[ro+1][co+1]);
            if (quad != expected) begin
                report_mismatch($sformatf("product quad %0d", q), expected, quad);
            end
        end
    endtask

    // ------------------------------
    // test sequence
    // ------------------------------

    initial begin
        logic [`SYS_ADDR_W-1:0] base;
        int                     assert_fails;
        void'($urandom(32'h95524aa4));
        clk           = 1'b0;
        arst_n        = 1'b0;
        weight_start  = 1'b0;
        feature_start = 1'b0;
        feature_base  = '0;
        mode          = 1'b0;
        quad_sel      = 2'd0;
        errors        = 0;
        fill_memory();
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(negedge clk);
        if ({weight_done, feature_done, result_ready} != 3'b000) begin
            report_mismatch("reset flags", 32'd0, 32'({weight_done, feature_done, result_ready}));
        end
        if (quad != '0) begin
            report_mismatch("reset quad", 32'd0, quad);
        end

        // weights reload every third round and the rounds between reuse them.
        for (int round = 0; round < ROUNDS; round++) begin
            fill_memory();
            if (round % 3 == 0) begin
                load_weights(round % 2 == 1 ? 4 : -1);
            end
            base = `SYS_ADDR_W'($urandom_range(55, 0));
            load_features(base, round % 4 == 2 ? 6 : -1);
            check_product(base);
        end

        assert_fails = systolic_top_inst.systolic_props_inst.reset_fails
                     + systolic_top_inst.systolic_props_inst.owner_fails
                     + systolic_top_inst.systolic_props_inst.hold_fails;
        $display("rounds %0d, check errors %0d, assertion failures %0d",
                 ROUNDS, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run is stuck", WATCHDOG_NS);
        $display("Errors found");
        $finish;
    end

endmodule

// ==== systolic_top.f ====
+incdir+hdl
hdl/systolic_pkg.sv
hdl/weight_preloader.sv
hdl/feature_loader.sv
hdl/operand_fetch.sv
hdl/pe.sv
hdl/systolic_array.sv
hdl/result_collector.sv
hdl/systolic_top.sv
testbench/systolic_props.sv
testbench/systolic_tb.sv

// ==== Makefile ====
# Verilator build and run of the systolic multiplier testbench.
TOP = systolic_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f systolic_top.f
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	@if grep -qx "No errors" $(LOG); then echo "test passed"; else echo "test failed"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
